// ==== hdl/eeprom_cfg.svh ====
`ifndef EEPROM_CFG_SVH
`define EEPROM_CFG_SVH

// 24C16 geometry, 2 Kbyte
`define EE_ADDR_W   11
`define EE_DATA_W   8
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of scl
`define EE_QTR      2

`endif

// ==== hdl/eeprom_pkg.sv ====
package eeprom_pkg;

    // host side request kind
    typedef enum logic
    {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_t;

    // commands from the sequencer to the bus engine
    // CMD_START doubles as repeated start
    typedef enum logic [2:0]
    {
        CMD_START     = 3'd0,
        CMD_SEND      = 3'd1, // byte out, slave ack sampled
        CMD_RECV_NACK = 3'd2, // byte in, master nack
        CMD_STOP      = 3'd3
    } bus_cmd_t;

endpackage

// ==== hdl/i2c_byte_engine.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module i2c_byte_engine (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_req,
    input  eeprom_pkg::bus_cmd_t cmd,
    input  logic [7:0]           cmd_byte,
    input  logic                 sda_in,
    output logic                 cmd_ack,
    output logic                 slave_nack,
    output logic [7:0]           rx_byte,
    output logic                 scl,
    output logic                 sda_out,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    localparam int QTR = `EE_QTR;
    localparam int QW  = (QTR > 1) ? $clog2(QTR) : 1;

    typedef enum logic [2:0]
    {
        E_IDLE,
        E_START,
        E_STOP,
        E_BYTE,
        E_DONE
    } eng_st_t;

    eng_st_t       state;
    eng_st_t       cmd_st;
    logic [QW-1:0] qcnt;
    logic [1:0]    q;       // quarter within a bit
    logic [3:0]    bit_idx; // 0..7 data, 8 ack
    logic          rx_mode;
    logic [7:0]    tx_sh;

    logic          active;
    logic          tick;
    logic          q_end;
    logic          last;
    logic          sample;
    logic          load;
    logic          advance;

    eng_st_t       step_st;
    logic [1:0]    step_q;
    logic [3:0]    step_bit;
    logic          step_tx;
    logic          step_rx;
    logic          scl_nxt;
    logic          oe_nxt;
    logic          out_nxt;

    always_comb
    begin
        case (cmd)
            CMD_START: cmd_st = E_START;
            CMD_STOP:  cmd_st = E_STOP;
            default:   cmd_st = E_BYTE;
        endcase
    end

    assign active  = (state == E_START) || (state == E_STOP) || (state == E_BYTE);
    assign tick    = active && (qcnt == QW'(QTR - 1));
    assign q_end   = tick && (q == 2'd3);
    assign last    = q_end && ((state != E_BYTE) || (bit_idx == 4'd8));
    assign sample  = (state == E_BYTE) && tick && (q == 2'd2); // end of third quarter
    assign load    = (state == E_IDLE) && cmd_req;
    assign advance = load || (tick && !last);

    // which quarter is entered next
    always_comb
    begin
        step_st  = state;
        step_q   = q + 2'd1;
        step_bit = bit_idx;
        step_tx  = tx_sh[7];
        step_rx  = rx_mode;
        if (load)
        begin
            step_st  = cmd_st;
            step_q   = 2'd0;
            step_bit = 4'd0;
            step_tx  = cmd_byte[7];
            step_rx  = (cmd == CMD_RECV_NACK);
        end
        else if (q_end)
        begin
            step_bit = bit_idx + 4'd1;
            step_tx  = tx_sh[6];
        end
    end

    // bus levels for that quarter
    always_comb
    begin
        scl_nxt = scl;
        oe_nxt  = 1'b0;
        out_nxt = 1'b1;
        case (step_st)
            E_START:
            begin
                scl_nxt = (step_q == 2'd0) ? scl : (step_q != 2'd3);
                oe_nxt  = step_q[1]; // sda falls while scl high
                out_nxt = !step_q[1];
            end
            E_STOP:
            begin
                scl_nxt = (step_q != 2'd0);
                oe_nxt  = !step_q[1]; // released with scl high gives the stop
                out_nxt = step_q[1];
            end
            E_BYTE:
            begin
                scl_nxt = (step_q == 2'd1) || (step_q == 2'd2);
                if (step_bit == 4'd8)
                begin
                    oe_nxt = step_rx; // high nack on receive, released for slave ack
                end
                else if (!step_rx)
                begin
                    oe_nxt  = 1'b1;
                    out_nxt = step_tx;
                end
            end
            default:
            begin
                oe_nxt  = sda_oe;
                out_nxt = sda_out;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= E_IDLE;
            qcnt    <= '0;
            q       <= 2'd0;
            bit_idx <= 4'd0;
            rx_mode <= 1'b0;
            cmd_ack <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            sda_out <= 1'b1;
        end
        else
        begin
            if (advance)
            begin
                scl     <= scl_nxt;
                sda_oe  <= oe_nxt;
                sda_out <= out_nxt;
            end
            case (state)
                E_IDLE:
                begin
                    if (cmd_req)
                    begin
                        state   <= cmd_st;
                        qcnt    <= '0;
                        q       <= 2'd0;
                        bit_idx <= 4'd0;
                        rx_mode <= (cmd == CMD_RECV_NACK);
                    end
                end
                E_DONE:
                begin
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;
                        state   <= E_IDLE;
                    end
                end
                default:
                begin
                    if (last)
                    begin
                        cmd_ack <= 1'b1;
                        state   <= E_DONE;
                    end
                    else if (tick)
                    begin
                        qcnt <= '0;
                        q    <= q + 2'd1;
                        if (q_end)
                            bit_idx <= bit_idx + 4'd1;
                    end
                    else
                    begin
                        qcnt <= qcnt + QW'(1);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (load)
            tx_sh <= cmd_byte;
        else if (q_end)
            tx_sh <= {tx_sh[6:0], 1'b0}; // msb first
        if (sample && rx_mode && (bit_idx != 4'd8))
            rx_byte <= {rx_byte[6:0], sda_in};
        if (sample && !rx_mode && (bit_idx == 4'd8))
            slave_nack <= sda_in; // high means no ack
    end

    a_sda_stable : assert property (@(posedge CLK) disable iff (RESET)
        (state == E_BYTE && scl && $past(scl)) |-> ($stable(sda_oe) && $stable(sda_out)));

    a_ack_needs_req : assert property (@(posedge CLK) disable iff (RESET)
        $rose(cmd_ack) |-> cmd_req);

endmodule

// ==== hdl/eeprom_seq.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_seq (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req,
    input  eeprom_pkg::op_t       op,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  cmd_ack,
    input  logic                  slave_nack,
    input  logic [7:0]            rx_byte,
    output logic                  ack,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  nack_err,
    output logic                  cmd_req,
    output eeprom_pkg::bus_cmd_t  cmd,
    output logic [7:0]            cmd_byte
);
    import eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_SEL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_SEL_R,
        S_RECV,
        S_STOP,
        S_ACK
    } seq_st_t;

    seq_st_t               state;
    seq_st_t               next_st;
    op_t                   op_r;
    logic [`EE_ADDR_W-1:0] addr_r;
    logic [`EE_DATA_W-1:0] wdata_r;
    logic                  is_send;
    logic                  cmd_done;

    assign is_send  = (state == S_SEL_W) || (state == S_ADDR) ||
                      (state == S_DATA) || (state == S_SEL_R);
    assign cmd_done = cmd_req && cmd_ack;

    // command for the current step
    always_comb
    begin
        cmd      = CMD_STOP;
        cmd_byte = 8'hFF;
        case (state)
            S_START, S_RSTART:
                cmd = CMD_START;
            S_SEL_W:
            begin
                cmd      = CMD_SEND;
                cmd_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b0};
            end
            S_ADDR:
            begin
                cmd      = CMD_SEND;
                cmd_byte = addr_r[7:0];
            end
            S_DATA:
            begin
                cmd      = CMD_SEND;
                cmd_byte = wdata_r;
            end
            S_SEL_R:
            begin
                cmd      = CMD_SEND;
                cmd_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b1};
            end
            S_RECV:
                cmd = CMD_RECV_NACK;
            default:
                cmd = CMD_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            S_START:  next_st = S_SEL_W;
            S_SEL_W:  next_st = slave_nack ? S_STOP : S_ADDR;
            S_ADDR:
            begin
                if (slave_nack)
                    next_st = S_STOP;
                else if (op_r == OP_READ)
                    next_st = S_RSTART;
                else
                    next_st = S_DATA;
            end
            S_RSTART: next_st = S_SEL_R;
            S_SEL_R:  next_st = slave_nack ? S_STOP : S_RECV;
            S_STOP:   next_st = S_ACK;
            default:  next_st = S_STOP; // data and receive both close with a stop
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= S_IDLE;
            ack      <= 1'b0;
            nack_err <= 1'b0;
            cmd_req  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (req && !ack)
                    begin
                        nack_err <= 1'b0;
                        state    <= S_START;
                    end
                end
                S_ACK:
                begin
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default:
                begin
                    if (cmd_req)
                    begin
                        if (cmd_ack)
                        begin
                            cmd_req <= 1'b0;
                            state   <= next_st;
                            if (is_send && slave_nack)
                                nack_err <= 1'b1;
                            if (state == S_STOP)
                                ack <= 1'b1;
                        end
                    end
                    else if (!cmd_ack)
                    begin
                        cmd_req <= 1'b1; // previous command fully retired
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && req && !ack)
        begin
            op_r    <= op;
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (cmd_done && state == S_RECV)
            rdata <= rx_byte;
    end

    // host must let go of req before ack drops
    a_ack_fall : assert property (@(posedge CLK) disable iff (RESET)
        $fell(ack) |-> !$past(req));

endmodule

// ==== hdl/eeprom_ctrl_top.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_ctrl_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req,
    input  eeprom_pkg::op_t       op,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  sda_in,
    output logic                  ack,
    output logic [`EE_DATA_W-1:0] rdata,
    output logic                  nack_err,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe
);
    import eeprom_pkg::*;

    logic       cmd_req;
    logic       cmd_ack;
    logic       slave_nack;
    logic [7:0] rx_byte;
    bus_cmd_t   cmd;
    logic [7:0] cmd_byte;

    eeprom_seq seq_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .req        (req),
        .op         (op),
        .addr       (addr),
        .wdata      (wdata),
        .cmd_ack    (cmd_ack),
        .slave_nack (slave_nack),
        .rx_byte    (rx_byte),
        .ack        (ack),
        .rdata      (rdata),
        .nack_err   (nack_err),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_byte   (cmd_byte)
    );

    // bus pins come only from here
    i2c_byte_engine engine_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_byte   (cmd_byte),
        .sda_in     (sda_in),
        .cmd_ack    (cmd_ack),
        .slave_nack (slave_nack),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

endmodule

// ==== verif/eeprom_model.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic pull   // 1 pulls the open-drain line low
);
    typedef enum logic [2:0]
    {
        M_IDLE,
        M_DEV,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } mdl_st_t;

    mdl_st_t               phase;
    logic                  scl_q;
    logic                  sda_q;
    logic [3:0]            bit_cnt;   // scl rises seen in this byte
    logic [7:0]            shreg;
    logic [7:0]            txreg;
    logic [2:0]            blk;
    logic [`EE_ADDR_W-1:0] ptr;
    logic                  rd_sel;
    logic                  acked;
    logic                  dev_ok;
    logic [`EE_ADDR_W-1:0] rd_addr;
    logic [7:0]            mem [0:(1 << `EE_ADDR_W)-1];

    // block 7 has no device behind it
    assign dev_ok  = (shreg[7:4] == `EE_DEV_CODE) && (shreg[3:1] != 3'd7);
    assign rd_addr = {blk, ptr[7:0]};

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            phase   <= M_IDLE;
            scl_q   <= 1'b1;
            sda_q   <= 1'b1;
            bit_cnt <= 4'd0;
            pull    <= 1'b0;
            acked   <= 1'b0;
            ptr     <= '0;
            mem     <= '{default: 8'hFF};
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                phase   <= M_DEV;  // start or repeated start
                bit_cnt <= 4'd0;
                pull    <= 1'b0;
            end
            else if (scl && scl_q && !sda_q && sda)
            begin
                phase <= M_IDLE;   // stop
                pull  <= 1'b0;
            end
            else if (phase != M_IDLE && scl && !scl_q)
            begin
                if (bit_cnt < 4'd8)
                    shreg <= {shreg[6:0], sda};
                bit_cnt <= bit_cnt + 4'd1;
            end
            else if (phase != M_IDLE && !scl && scl_q)
            begin
                if (phase == M_RDATA)
                begin
                    if (bit_cnt < 4'd8)
                    begin
                        pull  <= !txreg[6];
                        txreg <= {txreg[6:0], 1'b0};
                    end
                    else if (bit_cnt == 4'd8)
                    begin
                        pull <= 1'b0;   // master answers here
                    end
                    else
                    begin
                        pull    <= 1'b0;
                        bit_cnt <= 4'd0;
                        ptr     <= ptr + 11'd1;
                        phase   <= M_IDLE;
                    end
                end
                else if (bit_cnt == 4'd8)
                begin
                    // whole byte in, drive the ack bit
                    case (phase)
                        M_DEV:
                        begin
                            pull   <= dev_ok;
                            acked  <= dev_ok;
                            blk    <= shreg[3:1];
                            rd_sel <= shreg[0];
                        end
                        M_ADDR:
                        begin
                            pull  <= 1'b1;
                            acked <= 1'b1;
                            ptr   <= {blk, shreg};
                        end
                        default:
                        begin
                            pull     <= 1'b1;
                            acked    <= 1'b1;
                            mem[ptr] <= shreg;
                            ptr      <= ptr + 11'd1;
                        end
                    endcase
                end
                else if (bit_cnt == 4'd9)
                begin
                    pull    <= 1'b0;
                    bit_cnt <= 4'd0;
                    if (!acked)
                        phase <= M_IDLE;
                    else if (phase == M_DEV && rd_sel)
                    begin
                        phase <= M_RDATA;
                        ptr   <= rd_addr;
                        txreg <= mem[rd_addr];
                        pull  <= !mem[rd_addr][7];  // msb ready before first rise
                    end
                    else if (phase == M_DEV)
                        phase <= M_ADDR;
                    else
                        phase <= M_WDATA;
                end
            end
        end
    end

endmodule

// ==== verif/eeprom_checker.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module eeprom_checker (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req,
    input  eeprom_pkg::op_t       op,
    input  logic [`EE_ADDR_W-1:0] addr,
    input  logic [`EE_DATA_W-1:0] wdata,
    input  logic                  ack,
    input  logic [`EE_DATA_W-1:0] rdata,
    input  logic                  nack_err,
    input  logic                  scl,
    input  logic                  sda,
    output int                    value_errors,
    output int                    rule_errors,
    output int                    results_checked
);
    import eeprom_pkg::*;

    logic [`EE_DATA_W-1:0] shadow [0:(1 << `EE_ADDR_W)-1];
    logic                  ack_q;
    logic                  req_q;
    logic                  scl_q;
    logic                  sda_q;
    logic                  idle_seen;
    logic                  in_txn;
    logic                  txn_seen;
    int                    rises;   // scl rises since the last start
    logic                  start_ev;
    logic                  stop_ev;
    logic [8:0]            exp_res;

    assign start_ev = scl && scl_q && sda_q && !sda;
    assign stop_ev  = scl && scl_q && !sda_q && sda;

    // {nack_err, rdata} expected for a request
    function automatic logic [8:0] ref_result(input op_t o, input logic [`EE_ADDR_W-1:0] a);
        logic       no_dev;
        logic [7:0] d;
        no_dev = (a[10:8] == 3'd7);
        d      = 8'h00;
        if (o == OP_READ && !no_dev)
            d = shadow[a];
        return {no_dev, d};
    endfunction

    task automatic report_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        value_errors = value_errors + 1;
        $display("** Error at %0t ns: %s expected %02h, got %02h", $time, name, exp, act);
    endtask

    task automatic report_rule(input string what);
        rule_errors = rule_errors + 1;
        $display("bus or handshake rule broken at %0t ns: %s", $time, what);
    endtask

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            ack_q           <= 1'b0;
            req_q           <= 1'b0;
            scl_q           <= 1'b1;
            sda_q           <= 1'b1;
            idle_seen       <= 1'b0;
            in_txn          <= 1'b0;
            txn_seen        <= 1'b0;
            rises           <= 0;
            shadow          <= '{default: 8'hFF};
            value_errors    = 0;
            rule_errors     = 0;
            results_checked = 0;
        end
        else
        begin
            ack_q <= ack;
            req_q <= req;
            scl_q <= scl;
            sda_q <= sda;
            if (!idle_seen)
            begin
                idle_seen <= 1'b1;  // first cycle out of reset
                if (scl !== 1'b1)
                    report_value("scl", 8'h01, {7'd0, scl});
                if (sda !== 1'b1)
                    report_value("sda", 8'h01, {7'd0, sda});
                if (ack !== 1'b0)
                    report_value("ack", 8'h00, {7'd0, ack});
                if (nack_err !== 1'b0)
                    report_value("nack_err", 8'h00, {7'd0, nack_err});
            end
            if (scl && !scl_q)
                rises <= rises + 1;
            if (start_ev)
            begin
                if (ack)
                    report_rule("start condition while ack is high");
                if (in_txn && ((rises - 1) % 9 != 0))
                    report_rule("repeated start in the middle of a byte");
                in_txn   <= 1'b1;
                txn_seen <= 1'b1;
                rises    <= 0;
            end
            if (stop_ev)
            begin
                if (!in_txn)
                    report_rule("stop condition without a start");
                else if ((rises - 1) % 9 != 0)
                    report_rule("stop condition in the middle of a byte");
                in_txn <= 1'b0;
            end
            if (ack && !ack_q)
            begin
                if (in_txn)
                    report_rule("ack rose before the stop condition");
                if (!txn_seen)
                    report_rule("ack rose without any bus transaction");
                txn_seen        <= 1'b0;
                results_checked = results_checked + 1;
                exp_res         = ref_result(op, addr);
                if (nack_err !== exp_res[8])
                    report_value("nack_err", {7'd0, exp_res[8]}, {7'd0, nack_err});
                if (op == OP_READ && !exp_res[8] && rdata !== exp_res[7:0])
                    report_value("rdata", exp_res[7:0], rdata);
                if (op == OP_WRITE && !exp_res[8])
                    shadow[addr] <= wdata;
            end
            if (!ack && ack_q && req_q)
                report_rule("ack fell while req was still high");
        end
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ns
`include "eeprom_cfg.svh"

module tb_top;
    import eeprom_pkg::*;

    localparam int N_RANDOM    = 200;
    localparam int ACK_TIMEOUT = 2000;  // CLK cycles per handshake edge

    logic                  CLK;
    logic                  RESET;
    logic                  req;
    op_t                   op;
    logic [`EE_ADDR_W-1:0] addr;
    logic [`EE_DATA_W-1:0] wdata;
    logic                  ack;
    logic [`EE_DATA_W-1:0] rdata;
    logic                  nack_err;
    logic                  scl;
    logic                  sda_out;
    logic                  sda_oe;
    logic                  model_pull;
    logic                  sda;

    int                    value_errors;
    int                    rule_errors;
    int                    results_checked;
    int                    n_ops;
    int                    timeouts;
    int                    lost;
    logic                  timed_out;
    logic [31:0]           rng;
    op_t                   r_op;
    logic [`EE_ADDR_W-1:0] r_addr;
    logic [`EE_DATA_W-1:0] r_data;
    logic [3:0]            r_hold;

    // open-drain wire with pull-up
    assign sda = !((sda_oe && !sda_out) || model_pull);

    always #4 CLK = ~CLK;

    eeprom_ctrl_top dut_i (
        .CLK      (CLK),
        .RESET    (RESET),
        .req      (req),
        .op       (op),
        .addr     (addr),
        .wdata    (wdata),
        .sda_in   (sda),
        .ack      (ack),
        .rdata    (rdata),
        .nack_err (nack_err),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe)
    );

    eeprom_model model_i (
        .CLK   (CLK),
        .RESET (RESET),
        .scl   (scl),
        .sda   (sda),
        .pull  (model_pull)
    );

    eeprom_checker checker_i (
        .CLK             (CLK),
        .RESET           (RESET),
        .req             (req),
        .op              (op),
        .addr            (addr),
        .wdata           (wdata),
        .ack             (ack),
        .rdata           (rdata),
        .nack_err        (nack_err),
        .scl             (scl),
        .sda             (sda),
        .value_errors    (value_errors),
        .rule_errors     (rule_errors),
        .results_checked (results_checked)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // one full four-phase request
    task automatic run_op(input op_t o, input logic [`EE_ADDR_W-1:0] a,
                          input logic [`EE_DATA_W-1:0] d, input logic [3:0] hold);
        int cnt;
        if (!timed_out)
        begin
            @(posedge CLK);
            op    <= o;
            addr  <= a;
            wdata <= d;
            req   <= 1'b1;
            n_ops = n_ops + 1;
            cnt   = 0;
            while (!ack && cnt < ACK_TIMEOUT)
            begin
                @(posedge CLK);
                cnt = cnt + 1;
            end
            if (!ack)
            begin
                $display("timeout: ack never rose for the request to address %03h", a);
                timeouts  = timeouts + 1;
                timed_out = 1'b1;
            end
            else
            begin
                repeat (hold) @(posedge CLK);  // req kept up, ack and bus must stay put
                req <= 1'b0;
                cnt = 0;
                while (ack && cnt < ACK_TIMEOUT)
                begin
                    @(posedge CLK);
                    cnt = cnt + 1;
                end
                if (ack)
                begin
                    $display("timeout: ack stayed high after req fell, address %03h", a);
                    timeouts  = timeouts + 1;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    initial
    begin
        CLK       = 1'b0;
        RESET     = 1'b1;
        req       = 1'b0;
        op        = OP_WRITE;
        addr      = '0;
        wdata     = '0;
        rng       = 32'd21905;
        n_ops     = 0;
        timeouts  = 0;
        timed_out = 1'b0;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(posedge CLK);  // idle bus checked here

        run_op(OP_WRITE, 11'h123, 8'hA5, 4'd0);
        run_op(OP_READ, 11'h123, 8'h00, 4'd12);
        run_op(OP_WRITE, 11'h7AB, 8'h3C, 4'd9);  // no device at block 7
        run_op(OP_READ, 11'h7AB, 8'h00, 4'd0);
        run_op(OP_READ, 11'h3AB, 8'h00, 4'd0);
        run_op(OP_WRITE, 11'h3AB, 8'h5A, 4'd15);
        run_op(OP_READ, 11'h3AB, 8'h00, 4'd0);

        for (int i = 0; i < N_RANDOM; i++)
        begin
            rng    = xorshift32(rng);
            r_op   = rng[0] ? OP_READ : OP_WRITE;
            r_hold = rng[4:1];
            r_data = rng[27:20];
            if (rng[31:29] == 3'd0)
                r_addr = rng[18:8];
            else
                r_addr = {rng[18:16], 3'b000, rng[12:8]};  // small window, more read hits
            run_op(r_op, r_addr, r_data, r_hold);
        end

        repeat (4) @(posedge CLK);
        lost = n_ops - results_checked;
        if (lost != 0)
            $display("%0d requests finished without a result check", lost);
        $display("errors: value %0d, rule %0d, timeout %0d, unchecked %0d",
                 value_errors, rule_errors, timeouts, lost);
        if (value_errors == 0 && rule_errors == 0 && timeouts == 0 && lost == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/eeprom_pkg.sv
hdl/i2c_byte_engine.sv
hdl/eeprom_seq.sv
hdl/eeprom_ctrl_top.sv
verif/eeprom_model.sv
verif/eeprom_checker.sv
verif/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the serial EEPROM controller testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_top \
		--Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
